// File: tb.f
+incdir+hw
hw/spritePkg.sv
hw/rasterTileTracker.sv
hw/entityScanFsm.sv
hw/entityTable.sv
hw/spriteRom.sv
hw/spritePixelOut.sv
hw/tileRenderer.sv
verif/tileRenderer_properties.sv
verif/tileRendererTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tileRendererTb \
    -f tb.f -o tileRendererSim

if ./obj_dir/tileRendererSim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null; then
    echo "simulation passed"
else
    echo "simulation failed" >&2
    exit 1
fi

// File: verif/tileRendererTb.sv
`timescale 1ns/100ps
`default_nettype none

module tileRendererTb import spritePkg::*; ();

    localparam int HALF_PERIOD = 20;
    localparam int FRAMES = 4;
    localparam int CYCLE_LIMIT = FRAMES * H_TOTAL * V_TOTAL + 200;
    localparam logic [31:0] SEED = 32'h3d97_0edc;

    logic clk;
    logic reset;
    logic [9:0] hCount;
    logic [9:0] vCount;
    logic entityWe;
    logic [3:0] entityAddr;
    entity_t entityData;
    logic colour;

    // what the table holds, and what the next blanking writes
    entity_t model [NUM_SLOTS];
    entity_t pending [NUM_SLOTS];
    // expected colour of pixels still inside the DUT
    logic expectQ [$];
    int cycleCount = 0;

    // the ROM's copy of the table set the guard, this scope needs its own
    `undef SPRITE_ROM_DATA_SVH
    `include "spriteRomData.svh"

    tileRenderer #(
        .H_TILES(16),
        .V_TILES(12),
        .SLOTS(NUM_SLOTS)
    ) tileRenderer_inst (
        .clk(clk),
        .reset(reset),
        .hCount(hCount),
        .vCount(vCount),
        .entityWe(entityWe),
        .entityAddr(entityAddr),
        .entityData(entityData),
        .colour(colour)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkColour(input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: colour expected %b got %b", $time, expected, actual);
            abortRun();
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            abortRun();
        end
    end

    // screen pixel to colour, straight from the tile geometry
    function automatic logic expectedColour(input int h, input int v);
        int tileX;
        int tileY;
        logic [2:0] col;
        logic [2:0] row;
        logic [7:0] bits;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return 1'b0;
        end
        tileX = h / TILE_LEN;
        tileY = v / TILE_LEN;
        col = 3'((h % TILE_LEN) / UPSCALE);
        row = 3'((v % TILE_LEN) / UPSCALE);
        // lowest used slot on the tile wins
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (model[i].id != NO_SPRITE && int'(model[i].tileX) == tileX
                    && int'(model[i].tileY) == tileY) begin
                bits = spriteLine(model[i].id, model[i].orient[1] ? 3'd7 - row : row);
                return model[i].orient[0] ? bits[col] : bits[3'd7 - col];
            end
        end
        return 1'b0;
    endfunction

    task automatic pickEntities();
        int src;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            pending[i].id = 4'($urandom_range(0, 15));
            pending[i].orient = 2'($urandom_range(0, 3));
            pending[i].tileX = 4'($urandom_range(0, 15));
            pending[i].tileY = 4'($urandom_range(0, 11));
            // about a quarter of the slots pile onto an earlier slot's tile
            if (i > 0 && $urandom_range(0, 3) == 0) begin
                src = $urandom_range(0, i - 1);
                pending[i].tileX = pending[src].tileX;
                pending[i].tileY = pending[src].tileY;
            end
        end
        // an unused slot sitting under a live one must not hide it
        src = $urandom_range(0, NUM_SLOTS - 2);
        pending[src].id = NO_SPRITE;
        pending[NUM_SLOTS - 1].tileX = pending[src].tileX;
        pending[NUM_SLOTS - 1].tileY = pending[src].tileY;
    endtask

    task automatic stepPixel(input int h, input int v);
        hCount = 10'(h);
        vCount = 10'(v);
        // slots are rewritten on the second blanking line
        if (v == V_ACTIVE + 1 && h < NUM_SLOTS) begin
            entityWe = 1'b1;
            entityAddr = 4'(h);
            entityData = pending[h];
            model[h] = pending[h];
        end else begin
            entityWe = 1'b0;
        end
        expectQ.push_back(expectedColour(h, v));
    endtask

    initial begin
        int v;
        reset = 1'b0;
        hCount = '0;
        vCount = 10'(V_ACTIVE);
        entityWe = 1'b0;
        entityAddr = '0;
        entityData = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            model[i] = '{id: NO_SPRITE, orient: '0, tileX: '0, tileY: '0};
        end

        // black while reset is held
        repeat (2) begin
            @(negedge clk);
            checkColour(1'b0, colour);
        end
        reset = 1'b1;
        void'($urandom(SEED));

        // pipe holds reset values ahead of the first pixel
        repeat (LATENCY - 1) begin
            expectQ.push_back(1'b0);
        end

        // each frame starts in vertical blanking
        for (int frame = 0; frame < FRAMES; frame++) begin
            pickEntities();
            for (int k = 0; k < V_TOTAL; k++) begin
                v = (V_ACTIVE + k) % V_TOTAL;
                for (int h = 0; h < H_TOTAL; h++) begin
                    stepPixel(h, v);
                    @(negedge clk);
                    checkColour(expectQ.pop_front(), colour);
                end
            end
        end

        while (expectQ.size() > 0) begin
            @(negedge clk);
            checkColour(expectQ.pop_front(), colour);
        end

        if (tileRenderer_inst.entityScanFsm_inst.fsmProps.failures == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("scan FSM assertions failed %0d times",
                tileRenderer_inst.entityScanFsm_inst.fsmProps.failures);
            abortRun();
        end
    end

endmodule

`default_nettype wire

// File: verif/tileRenderer_properties.sv
`timescale 1ns/100ps
`default_nettype none

module tileRenderer_properties import spritePkg::*; #(
    parameter int SLOTS = NUM_SLOTS
) (
    input logic clk,
    input logic reset,
    input logic scanStart,
    input logic done,
    input scanState_t state
);

    int failures = 0;
    int sinceStart;

    // 1 on the cycle after a request
    always_ff @(posedge clk) begin
        if (!reset) begin
            sinceStart <= 0;
        end else if (scanStart) begin
            sinceStart <= 1;
        end else begin
            sinceStart <= sinceStart + 1;
        end
    end

    // one step into SCAN, one per slot, then DONE
    doneAfterScan: assert property (@(posedge clk) disable iff (!reset)
        scanStart |-> ##(SLOTS + 1) done)
    else begin
        failures = failures + 1;
        $error("scan request not followed by DONE after %0d cycles", SLOTS + 1);
    end

    doneNotEarly: assert property (@(posedge clk) disable iff (!reset)
        done |-> sinceStart == SLOTS + 1)
    else begin
        failures = failures + 1;
        $error("DONE after %0d cycles instead of %0d", sinceStart, SLOTS + 1);
    end

    startWhileIdle: assert property (@(posedge clk) disable iff (!reset)
        scanStart |-> state == IDLE)
    else begin
        failures = failures + 1;
        $error("scan request arrived in state %s", state.name());
    end

endmodule

bind entityScanFsm tileRenderer_properties #(
    .SLOTS(SLOTS)
) fsmProps (
    .clk(clk),
    .reset(reset),
    .scanStart(scanStart),
    .done(done),
    .state(state)
);

`default_nettype wire

// File: hw/tileRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module tileRenderer import spritePkg::*; #(
    parameter int H_TILES = 16,
    parameter int V_TILES = 12,
    parameter int SLOTS = NUM_SLOTS
) (
    input logic clk,
    input logic reset,
    input logic [9:0] hCount,
    input logic [9:0] vCount,
    input logic entityWe,
    input logic [3:0] entityAddr,
    input entity_t entityData,
    output logic colour
);

    logic scanStart;
    logic tileEdge;
    logic active;
    logic [2:0] col;
    logic [2:0] line;
    logic [3:0] nextTileX;
    logic [3:0] nextTileY;

    logic [3:0] slotAddr;
    entity_t slotData;

    spriteId_t matchId;
    orient_t matchOrient;
    logic matchValid;
    logic [2:0] romLine;
    logic scanDone;
    logic [7:0] pendingLine;

    rasterTileTracker #(
        .H_TILES(H_TILES),
        .V_TILES(V_TILES)
    ) rasterTileTracker_inst (
        .clk(clk),
        .reset(reset),
        .hCount(hCount),
        .vCount(vCount),
        .scanStart(scanStart),
        .tileEdge(tileEdge),
        .active(active),
        .col(col),
        .line(line),
        .nextTileX(nextTileX),
        .nextTileY(nextTileY)
    );

    entityScanFsm #(
        .SLOTS(SLOTS)
    ) entityScanFsm_inst (
        .clk(clk),
        .reset(reset),
        .scanStart(scanStart),
        .nextTileX(nextTileX),
        .nextTileY(nextTileY),
        .line(line),
        .slotData(slotData),
        .slotAddr(slotAddr),
        .matchId(matchId),
        .matchOrient(matchOrient),
        .matchValid(matchValid),
        .romLine(romLine),
        .done(scanDone)
    );

    entityTable #(
        .SLOTS(SLOTS)
    ) entityTable_inst (
        .clk(clk),
        .reset(reset),
        .we(entityWe),
        .wrAddr(entityAddr),
        .wrData(entityData),
        .rdAddr(slotAddr),
        .rdData(slotData)
    );

    // no match reads the empty sprite
    spriteRom spriteRom_inst (
        .clk(clk),
        .reset(reset),
        .load(scanDone),
        .spriteId(matchValid ? matchId : NO_SPRITE),
        .lineIdx(romLine),
        .pendingLine(pendingLine)
    );

    spritePixelOut spritePixelOut_inst (
        .clk(clk),
        .reset(reset),
        .tileEdge(tileEdge),
        .active(active),
        .col(col),
        .pendingLine(pendingLine),
        .mirror(matchOrient[0]),
        .colour(colour)
    );

endmodule

`default_nettype wire

// File: hw/spritePixelOut.sv
`timescale 1ns/100ps
`default_nettype none

module spritePixelOut (
    input logic clk,
    input logic reset,
    input logic tileEdge,
    input logic active,
    input logic [2:0] col,
    input logic [7:0] pendingLine,
    input logic mirror,
    output logic colour
);

    logic [7:0] curLine;
    logic curMirror;
    logic [7:0] lineSel;
    logic mirrorSel;
    logic [2:0] bitIdx;
    logic pixBit;
    logic activeD;

    // first pixel of a tile already draws from the new line
    assign lineSel = tileEdge ? pendingLine : curLine;
    assign mirrorSel = tileEdge ? mirror : curMirror;
    assign bitIdx = mirrorSel ? col : 3'd7 - col;

    always_ff @(posedge clk) begin
        if (!reset) begin
            curLine <= '0;
            curMirror <= 1'b0;
            pixBit <= 1'b0;
            activeD <= 1'b0;
            colour <= 1'b0;
        end else begin
            if (tileEdge) begin
                curLine <= pendingLine;
                curMirror <= mirror;
            end
            pixBit <= lineSel[bitIdx];
            activeD <= active;
            // black in blanking
            colour <= pixBit && activeD;
        end
    end

endmodule

`default_nettype wire

// File: hw/spriteRom.sv
`timescale 1ns/100ps
`default_nettype none

module spriteRom import spritePkg::*; (
    input logic clk,
    input logic reset,
    input logic load,
    input spriteId_t spriteId,
    input logic [2:0] lineIdx,
    output logic [7:0] pendingLine
);

    `include "spriteRomData.svh"

    // lineIdx comes in already flipped for vertical orientation
    always_ff @(posedge clk) begin
        if (!reset) begin
            pendingLine <= '0;
        end else if (load) begin
            pendingLine <= spriteLine(spriteId, lineIdx);
        end
    end

endmodule

`default_nettype wire

// File: hw/entityTable.sv
`timescale 1ns/100ps
`default_nettype none

module entityTable import spritePkg::*; #(
    parameter int SLOTS = NUM_SLOTS
) (
    input logic clk,
    input logic reset,
    input logic we,
    input logic [3:0] wrAddr,
    input entity_t wrData,
    input logic [3:0] rdAddr,
    output entity_t rdData
);

    localparam entity_t EMPTY = '{id: NO_SPRITE, orient: '0, tileX: '0, tileY: '0};

    entity_t slots [SLOTS];

    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < SLOTS; i++) begin
                slots[i] <= EMPTY;
            end
        end else if (we && wrAddr < 4'(SLOTS)) begin
            slots[wrAddr] <= wrData;
        end
    end

    // addresses past the last slot read as unused
    assign rdData = (rdAddr < 4'(SLOTS)) ? slots[rdAddr] : EMPTY;

endmodule

`default_nettype wire

// File: hw/entityScanFsm.sv
`timescale 1ns/100ps
`default_nettype none

module entityScanFsm import spritePkg::*; #(
    parameter int SLOTS = NUM_SLOTS
) (
    input logic clk,
    input logic reset,
    input logic scanStart,
    input logic [3:0] nextTileX,
    input logic [3:0] nextTileY,
    input logic [2:0] line,
    input entity_t slotData,
    output logic [3:0] slotAddr,
    output spriteId_t matchId,
    output orient_t matchOrient,
    output logic matchValid,
    output logic [2:0] romLine,
    output logic done
);

    scanState_t state;
    logic hit;

    // slot in use and sitting on the requested tile
    assign hit = slotData.id != NO_SPRITE
        && slotData.tileX == nextTileX
        && slotData.tileY == nextTileY;

    assign done = state == DONE;

    // line stays put until the next request, so the flip can be done here
    assign romLine = matchOrient[1] ? 3'd7 - line : line;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= IDLE;
            slotAddr <= '0;
            matchId <= NO_SPRITE;
            matchOrient <= '0;
            matchValid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // matchId keeps its old value, only matchValid qualifies it
                    if (scanStart) begin
                        state <= SCAN;
                        slotAddr <= '0;
                        matchOrient <= '0;
                        matchValid <= 1'b0;
                    end
                end
                SCAN: begin
                    // lowest slot wins and later hits are ignored
                    if (hit && !matchValid) begin
                        matchId <= slotData.id;
                        matchOrient <= slotData.orient;
                        matchValid <= 1'b1;
                    end
                    if (slotAddr == 4'(SLOTS - 1)) begin
                        state <= DONE;
                    end else begin
                        slotAddr <= slotAddr + 4'd1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/rasterTileTracker.sv
`timescale 1ns/100ps
`default_nettype none

module rasterTileTracker import spritePkg::*; #(
    parameter int H_TILES = 16,
    parameter int V_TILES = 12
) (
    input logic clk,
    input logic reset,
    input logic [9:0] hCount,
    input logic [9:0] vCount,
    output logic scanStart,
    output logic tileEdge,
    output logic active,
    output logic [2:0] col,
    output logic [2:0] line,
    output logic [3:0] nextTileX,
    output logic [3:0] nextTileY
);

    logic [2:0] hUp;
    logic [3:0] tileX;
    logic [2:0] vUp;
    logic [2:0] row;
    logic [3:0] tileY;

    logic [2:0] hUpN;
    logic [2:0] colN;
    logic [3:0] tileXN;
    logic [2:0] vUpStep;
    logic [2:0] rowStep;
    logic [3:0] tileYStep;
    logic [2:0] vUpN;
    logic [2:0] rowN;
    logic [3:0] tileYN;

    logic hUpLast;
    logic hTileEnd;
    logic hActive;
    logic vActive;
    logic tileFirst;
    logic lastLine;
    logic inLineScan;
    logic edgeScan;

    assign hUpLast = hUp == 3'(UPSCALE - 1);
    // previous pixel was the last one of a tile
    assign hTileEnd = hUpLast && col == 3'(TILE_PIX - 1);
    assign hActive = hCount < 10'(H_ACTIVE);
    assign vActive = vCount < 10'(V_ACTIVE);
    assign lastLine = vCount == 10'(V_TOTAL - 1);

    // horizontal position of the pixel now on hCount
    always_comb begin
        if (hCount == '0) begin
            hUpN = '0;
            colN = '0;
            tileXN = '0;
        end else if (!hUpLast) begin
            hUpN = hUp + 3'd1;
            colN = col;
            tileXN = tileX;
        end else begin
            hUpN = '0;
            colN = col + 3'd1;
            tileXN = (col == 3'(TILE_PIX - 1)) ? tileX + 4'd1 : tileX;
        end
    end

    // vertical position one line further, also used for the next line's request
    always_comb begin
        if (vUp != 3'(UPSCALE - 1)) begin
            vUpStep = vUp + 3'd1;
            rowStep = row;
            tileYStep = tileY;
        end else begin
            vUpStep = '0;
            rowStep = row + 3'd1;
            if (row != 3'(TILE_PIX - 1)) begin
                tileYStep = tileY;
            end else begin
                tileYStep = (tileY == 4'(V_TILES - 1)) ? 4'd0 : tileY + 4'd1;
            end
        end

        // vertical counters move only when hCount wraps
        if (hCount != '0) begin
            vUpN = vUp;
            rowN = row;
            tileYN = tileY;
        end else if (vCount == '0) begin
            vUpN = '0;
            rowN = '0;
            tileYN = '0;
        end else begin
            vUpN = vUpStep;
            rowN = rowStep;
            tileYN = tileYStep;
        end
    end

    assign tileFirst = hActive && vActive && (hCount == '0 || hTileEnd);
    // the last tile of a line asks for nothing, the blanking request covers tile 0
    assign inLineScan = tileFirst && tileXN != 4'(H_TILES - 1);
    assign edgeScan = hCount == 10'(H_ACTIVE) && (lastLine || vCount < 10'(V_ACTIVE - 1));

    always_ff @(posedge clk) begin
        if (!reset) begin
            hUp <= '0;
            col <= '0;
            tileX <= '0;
            vUp <= '0;
            row <= '0;
            tileY <= '0;
            active <= 1'b0;
            tileEdge <= 1'b0;
            scanStart <= 1'b0;
            nextTileX <= '0;
            nextTileY <= '0;
            line <= '0;
        end else begin
            hUp <= hUpN;
            col <= colN;
            tileX <= tileXN;
            vUp <= vUpN;
            row <= rowN;
            tileY <= tileYN;
            active <= hActive && vActive;
            tileEdge <= tileFirst;
            scanStart <= inLineScan || edgeScan;
            if (inLineScan) begin
                nextTileX <= tileXN + 4'd1;
                nextTileY <= tileYN;
                line <= rowN;
            end else if (edgeScan) begin
                // tile 0 of the coming line
                nextTileX <= '0;
                nextTileY <= lastLine ? 4'd0 : tileYStep;
                line <= lastLine ? 3'd0 : rowStep;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/spritePkg.sv
`default_nettype none

package spritePkg;

    // screen geometry
    localparam int UPSCALE = 5;
    localparam int TILE_PIX = 8;
    localparam int TILE_LEN = UPSCALE * TILE_PIX;

    localparam int H_ACTIVE = 640;
    localparam int V_ACTIVE = 480;
    localparam int H_TOTAL = 800;
    localparam int V_TOTAL = 525;

    localparam int NUM_SLOTS = 9;

    typedef logic [3:0] spriteId_t;

    // bit 0 mirrors horizontally, bit 1 flips vertically
    typedef logic [1:0] orient_t;

    // one entity slot, 14 bits
    typedef struct packed {
        spriteId_t id;
        orient_t orient;
        logic [3:0] tileX;
        logic [3:0] tileY;
    } entity_t;

    // marks a slot as unused
    localparam spriteId_t NO_SPRITE = 4'hF;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        DONE
    } scanState_t;

    // counters in, registered pixel bit, registered output
    localparam int LATENCY = 3;

endpackage

`default_nettype wire

// File: hw/spriteRomData.svh
`ifndef SPRITE_ROM_DATA_SVH
`define SPRITE_ROM_DATA_SVH

// top byte of each bitmap is line 0, msb is the leftmost pixel
function automatic logic [7:0] spriteLine(input logic [3:0] spriteId,
                                          input logic [2:0] lineIdx);
    logic [63:0] bitmap;
    case (spriteId)
        4'd0: bitmap = 64'hFF81_8181_8181_81FF;
        4'd1: bitmap = 64'h1818_18FF_FF18_1818;
        4'd2: bitmap = 64'h8040_2010_0804_0201;
        4'd3: bitmap = 64'hAA55_AA55_AA55_AA55;
        4'd4: bitmap = 64'h3C42_A581_A599_423C;
        // arrow, asymmetric on both axes
        4'd5: bitmap = 64'h1030_7FFF_7F30_1000;
        4'd6: bitmap = 64'h7E40_407C_4040_4000;
        4'd7: bitmap = 64'h4040_4040_4040_7E00;
        4'd8: bitmap = 64'h0103_070F_1F3F_7FFF;
        4'd9: bitmap = 64'hFFFF_FFFF_FFFF_FFFF;
        4'd10: bitmap = 64'h66FF_FFFF_7E3C_1800;
        4'd11: bitmap = 64'hFF00_FF00_FF00_FF00;
        4'd12: bitmap = 64'h3C7E_E7C3_C3E7_7E3C;
        4'd13: bitmap = 64'hE0A0_E040_4070_4070;
        4'd14: bitmap = 64'hC060_3018_0C06_0300;
        // ID 15 is the empty sprite
        default: bitmap = 64'h0;
    endcase
    return bitmap[(3'd7 - lineIdx) * 8 +: 8];
endfunction

`endif
